// File: icache_ctrl_unit.f
logic/icache_ctrl_pkg.sv
logic/icache_ctrl_regs.sv
logic/icache_ack_tracker.sv
logic/icache_ctrl_fsm.sv
logic/icache_ctrl_unit.sv
tests/icache_ctrl_unit_sva.sv
tests/icache_ctrl_unit_tb.sv

// File: logic/icache_ack_tracker.sv
// Sticky per-core acknowledge collection for a pending bypass or flush
`default_nettype none

module icache_ack_tracker (
    input  wire logic                       clk_i,
    input  wire logic                       rst_ni,
    input  wire icache_ctrl_pkg::track_op_e track_op_i,
    input  wire icache_ctrl_pkg::core_req_t core_req_i,
    input  wire icache_ctrl_pkg::core_ack_t core_ack_i,
    output logic                            done_o
);

    import icache_ctrl_pkg::*;

    logic [NB_CORES-1:0] settled_q;
    logic [NB_CORES-1:0] match;
    logic [NB_CORES-1:0] seen;

    // Per-core settle condition for the selected operation
    always_comb
    begin
        case (track_op_i)
            TRACK_BYPASS:
            begin
                match = ~(core_ack_i.bypass_ack ^ core_req_i.bypass_req);
            end
            TRACK_FLUSH:
            begin
                // Cores without a flush request count as done
                match = ~core_req_i.flush_req | core_ack_i.flush_ack;
            end
            default:
            begin
                match = '0;
            end
        endcase
    end

    assign seen   = settled_q | match;
    assign done_o = (track_op_i != TRACK_NONE) && (&seen);

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            settled_q <= '0;
        end
        else if (done_o || track_op_i == TRACK_NONE)
        begin
            settled_q <= '0; // Fresh start for the next operation
        end
        else
        begin
            settled_q <= seen;
        end
    end

endmodule

`default_nettype wire

// File: logic/icache_ctrl_fsm.sv
// Peripheral bus FSM with grant, ack waiting states and registered response
`default_nettype none

module icache_ctrl_fsm (
    input  wire logic                         clk_i,
    input  wire logic                         rst_ni,
    input  wire icache_ctrl_pkg::periph_req_t bus_req_i,
    input  wire icache_ctrl_pkg::wr_op_e      wr_op_i,
    input  wire logic [31:0]                  rd_data_i,
    input  wire logic                         track_done_i,
    output icache_ctrl_pkg::periph_rsp_t      bus_rsp_o,
    output logic                              accept_o,
    output icache_ctrl_pkg::track_op_e        track_op_o,
    output logic                              flush_clear_o
);

    import icache_ctrl_pkg::*;

    ctrl_state_e         state_q;
    ctrl_state_e         state_d;
    logic                gnt;
    logic                rsp_set;
    logic [31:0]         rsp_data;
    logic                r_valid_q;
    logic [ID_WIDTH-1:0] r_id_q;
    logic [31:0]         r_rdata_q;

    assign gnt      = (state_q == IDLE);
    assign accept_o = bus_req_i.req & gnt;

    always_comb
    begin
        state_d  = state_q;
        rsp_set  = 1'b0;
        rsp_data = '0;

        case (state_q)
            IDLE:
            begin
                if (accept_o)
                begin
                    if (bus_req_i.wen)
                    begin
                        rsp_set  = 1'b1; // Read data sampled now
                        rsp_data = rd_data_i;
                    end
                    else
                    begin
                        case (wr_op_i)
                            WR_BYPASS: state_d = WAIT_BYPASS;
                            WR_FLUSH:  state_d = WAIT_FLUSH;
                            default:   rsp_set = 1'b1;
                        endcase
                    end
                end
            end

            WAIT_BYPASS, WAIT_FLUSH:
            begin
                if (track_done_i)
                begin
                    state_d = IDLE;
                    rsp_set = 1'b1;
                end
            end

            default:
            begin
                state_d = IDLE;
            end
        endcase
    end

    always_comb
    begin
        case (state_q)
            WAIT_BYPASS: track_op_o = TRACK_BYPASS;
            WAIT_FLUSH:  track_op_o = TRACK_FLUSH;
            default:     track_op_o = TRACK_NONE;
        endcase
    end

    assign flush_clear_o = (state_q == WAIT_FLUSH) & track_done_i;

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            state_q   <= IDLE;
            r_valid_q <= 1'b0;
        end
        else
        begin
            state_q   <= state_d;
            r_valid_q <= rsp_set;
        end
    end

    // Response payload, id held from acceptance until the reply
    always_ff @(posedge clk_i)
    begin
        if (accept_o)
        begin
            r_id_q <= bus_req_i.id;
        end
        if (rsp_set)
        begin
            r_rdata_q <= rsp_data;
        end
    end

    always_comb
    begin
        bus_rsp_o.gnt     = gnt;
        bus_rsp_o.r_valid = r_valid_q;
        bus_rsp_o.r_opc   = 1'b0;
        bus_rsp_o.r_id    = r_id_q;
        bus_rsp_o.r_rdata = r_rdata_q;
    end

endmodule

`default_nettype wire

// File: logic/icache_ctrl_pkg.sv
// Instruction cache control unit shared constants, bus and core types
`default_nettype none

package icache_ctrl_pkg;

    localparam int unsigned NB_CORES = 8;
    localparam int unsigned ID_WIDTH = 5;

    // Word index taken from address bits 7:2
    localparam int unsigned WORD_IDX_LSB = 2;
    localparam int unsigned WORD_IDX_W   = 6;

    localparam logic [WORD_IDX_W-1:0] ADDR_BYPASS = 6'd0;
    localparam logic [WORD_IDX_W-1:0] ADDR_FLUSH  = 6'd1;
    localparam logic [WORD_IDX_W-1:0] ADDR_MAGIC  = 6'd2;

    localparam logic [31:0] MAGIC_WORD    = 32'hBADD_A555;
    localparam logic [31:0] UNMAPPED_WORD = 32'hDEAD_A555;

    // Peripheral bus request, wen high means read
    typedef struct packed {
        logic                req;
        logic [31:0]         addr;
        logic                wen;
        logic [31:0]         wdata;
        logic [3:0]          be;
        logic [ID_WIDTH-1:0] id;
    } periph_req_t;

    typedef struct packed {
        logic                gnt;
        logic                r_valid;
        logic                r_opc;
        logic [ID_WIDTH-1:0] r_id;
        logic [31:0]         r_rdata;
    } periph_rsp_t;

    // One bit per core towards the caches
    typedef struct packed {
        logic [NB_CORES-1:0] bypass_req;
        logic [NB_CORES-1:0] flush_req;
    } core_req_t;

    typedef struct packed {
        logic [NB_CORES-1:0] bypass_ack;
        logic [NB_CORES-1:0] flush_ack;
    } core_ack_t;

    typedef enum logic [1:0] {
        WR_NONE,
        WR_BYPASS,
        WR_FLUSH,
        WR_OTHER
    } wr_op_e;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_BYPASS,
        WAIT_FLUSH
    } ctrl_state_e;

    typedef enum logic [1:0] {
        TRACK_NONE,
        TRACK_BYPASS,
        TRACK_FLUSH
    } track_op_e;

endpackage

`default_nettype wire

// File: logic/icache_ctrl_regs.sv
// Bypass and flush control registers with write decode and read mux
`default_nettype none

module icache_ctrl_regs (
    input  wire logic                         clk_i,
    input  wire logic                         rst_ni,
    input  wire icache_ctrl_pkg::periph_req_t bus_req_i,
    input  wire logic                         accept_i,
    input  wire logic                         flush_clear_i,
    output icache_ctrl_pkg::wr_op_e           wr_op_o,
    output logic [31:0]                       rd_data_o,
    output icache_ctrl_pkg::core_req_t        core_req_o
);

    import icache_ctrl_pkg::*;

    logic [WORD_IDX_W-1:0] word_idx;
    logic                  wr_accept;
    logic [31:0]           bypass_q;
    logic [31:0]           flush_q;

    assign word_idx  = bus_req_i.addr[WORD_IDX_LSB +: WORD_IDX_W];
    assign wr_accept = accept_i & ~bus_req_i.wen;

    // Kind of write seen in the accept cycle
    always_comb
    begin
        wr_op_o = WR_NONE;
        if (wr_accept)
        begin
            case (word_idx)
                ADDR_BYPASS: wr_op_o = WR_BYPASS;
                ADDR_FLUSH:  wr_op_o = WR_FLUSH;
                default:     wr_op_o = WR_OTHER;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            bypass_q <= '0;
        end
        else if (wr_accept && word_idx == ADDR_BYPASS)
        begin
            bypass_q <= bus_req_i.wdata;
        end
    end

    // Flush mask is dropped once every selected core has flushed
    always_ff @(posedge clk_i or negedge rst_ni)
    begin
        if (!rst_ni)
        begin
            flush_q <= '0;
        end
        else if (flush_clear_i)
        begin
            flush_q <= '0;
        end
        else if (wr_accept && word_idx == ADDR_FLUSH)
        begin
            flush_q <= bus_req_i.wdata;
        end
    end

    always_comb
    begin
        case (word_idx)
            ADDR_BYPASS: rd_data_o = bypass_q;
            ADDR_FLUSH:  rd_data_o = flush_q;
            ADDR_MAGIC:  rd_data_o = MAGIC_WORD;
            default:     rd_data_o = UNMAPPED_WORD;
        endcase
    end

    // A set bit enables the cache, so the request is the inverse
    assign core_req_o.bypass_req = ~bypass_q[NB_CORES-1:0];
    assign core_req_o.flush_req  = flush_q[NB_CORES-1:0];

endmodule

`default_nettype wire

// File: logic/icache_ctrl_unit.sv
// Instruction cache control unit top, joins registers, ack tracker and bus FSM
`default_nettype none

module icache_ctrl_unit (
    input  wire logic                         clk_i,
    input  wire logic                         rst_ni,
    input  wire icache_ctrl_pkg::periph_req_t bus_req_i,
    output icache_ctrl_pkg::periph_rsp_t      bus_rsp_o,
    output icache_ctrl_pkg::core_req_t        core_req_o,
    input  wire icache_ctrl_pkg::core_ack_t   core_ack_i
);

    import icache_ctrl_pkg::*;

    logic        accept;
    logic        flush_clear;
    logic        track_done;
    logic [31:0] rd_data;
    wr_op_e      wr_op;
    track_op_e   track_op;
    core_req_t   core_req;

    icache_ctrl_regs regs_i (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .bus_req_i     (bus_req_i),
        .accept_i      (accept),
        .flush_clear_i (flush_clear),
        .wr_op_o       (wr_op),
        .rd_data_o     (rd_data),
        .core_req_o    (core_req)
    );

    // Tracker watches the same requests that go out to the caches
    icache_ack_tracker tracker_i (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .track_op_i (track_op),
        .core_req_i (core_req),
        .core_ack_i (core_ack_i),
        .done_o     (track_done)
    );

    icache_ctrl_fsm fsm_i (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .bus_req_i     (bus_req_i),
        .wr_op_i       (wr_op),
        .rd_data_i     (rd_data),
        .track_done_i  (track_done),
        .bus_rsp_o     (bus_rsp_o),
        .accept_o      (accept),
        .track_op_o    (track_op),
        .flush_clear_o (flush_clear)
    );

    assign core_req_o = core_req;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the control unit simulation with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module icache_ctrl_unit_tb -f icache_ctrl_unit.f \
    --Mdir obj_dir -o icache_ctrl_unit_sim > build.log 2>&1 ||
    { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/icache_ctrl_unit_sim > sim.log 2>&1
cat sim.log

grep -q "Test FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Test OK" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"

// File: tests/icache_ctrl_unit_stim.txt
// Columns op_addr_data_id: op 1 read with expected rdata, op 2 write with wdata, op F ends
// addr is the byte address (word index in bits 7:2), id is the transaction id
1_00_00000000_01
1_04_00000000_02
1_08_BADDA555_03
1_14_DEADA555_04
1_0C_DEADA555_05
2_00_0000005A_06
1_00_0000005A_07
2_04_000000C3_08
1_04_00000000_09
2_00_000000FF_0A
1_00_000000FF_0B
2_04_000000FF_0C
1_04_00000000_0D
2_14_12345678_0E
1_00_000000FF_0F
1_04_00000000_10
1_14_DEADA555_11
2_00_00000000_12
1_00_00000000_13
2_04_00000001_14
2_04_00000000_15
1_08_BADDA555_16
2_00_FFFFFF0F_17
1_00_FFFFFF0F_18
2_04_00000080_19
1_04_00000000_1A
1_3C_DEADA555_1B
F_00_00000000_00

// File: tests/icache_ctrl_unit_sva.sv
// Protocol assertions for the control unit bus FSM
`default_nettype none

module icache_ctrl_unit_sva (
    input wire logic                         clk_i,
    input wire logic                         rst_ni,
    input wire icache_ctrl_pkg::periph_req_t bus_req_i,
    input wire icache_ctrl_pkg::periph_rsp_t bus_rsp_i,
    input wire icache_ctrl_pkg::ctrl_state_e state_i,
    input wire logic                         accept_i
);

    timeunit 1ns;
    timeprecision 1ps;

    import icache_ctrl_pkg::*;

    logic waiting;
    logic read_accept;
    logic gnt;
    logic r_valid;
    logic r_opc;

    assign waiting     = (state_i == WAIT_BYPASS) || (state_i == WAIT_FLUSH);
    assign read_accept = accept_i & bus_req_i.wen;
    assign gnt         = bus_rsp_i.gnt;
    assign r_valid     = bus_rsp_i.r_valid;
    assign r_opc       = bus_rsp_i.r_opc;

    // No new request while a write waits on the caches
    gnt_low_while_waiting: assert property (
        @(posedge clk_i) disable iff (!rst_ni) waiting |-> !gnt
    ) else $error("Grant high in a wait state");

    r_opc_zero: assert property (
        @(posedge clk_i) disable iff (!rst_ni) !r_opc
    ) else $error("Response opcode is not zero");

    read_response_next: assert property (
        @(posedge clk_i) disable iff (!rst_ni) read_accept |=> r_valid
    ) else $error("Accepted read without a response in the next cycle");

endmodule

`default_nettype wire

// File: tests/icache_ctrl_unit_tb.sv
// Testbench for the instruction cache control unit, driven from a stimulus file
`default_nettype none

module icache_ctrl_unit_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import icache_ctrl_pkg::*;

    localparam int          MAX_LINES  = 64;
    localparam logic [3:0]  OP_READ    = 4'h1;
    localparam logic [3:0]  OP_WRITE   = 4'h2;
    localparam logic [3:0]  OP_END     = 4'hF;
    localparam logic [7:0]  PROBE_ADDR = 8'h08;
    localparam logic [31:0] PROBE_WORD = 32'hBADD_A555;

    logic        clk_i;
    logic        rst_ni;
    periph_req_t bus_req;
    periph_rsp_t bus_rsp;
    core_req_t   core_req;
    core_ack_t   core_ack;

    logic [51:0] stim_mem [MAX_LINES];
    logic [2:0]  byp_wait [NB_CORES];
    logic [2:0]  fl_wait [NB_CORES];
    int          seed        = 32'h72f8cfc6;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          error_count = 0;
    int          num_lines;

    icache_ctrl_unit icache_ctrl_unit_i (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .bus_req_i  (bus_req),
        .bus_rsp_o  (bus_rsp),
        .core_req_o (core_req),
        .core_ack_i (core_ack)
    );

    bind icache_ctrl_fsm icache_ctrl_unit_sva fsm_sva_i (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .bus_req_i (bus_req_i),
        .bus_rsp_i (bus_rsp_o),
        .state_i   (state_q),
        .accept_i  (accept_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1, "Run aborted");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            error_count++;
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            abort_run("Stopping at the first mismatch");
        end
    endtask

    function automatic logic [2:0] next_delay();
        int r;
        r = $random(seed);
        return r[2:0];
    endfunction

    // Caches follow the requests after 0 to 7 cycles
    always @(posedge clk_i)
    begin
        if (!rst_ni)
        begin
            core_ack.bypass_ack <= '1;
            core_ack.flush_ack  <= '0;
            for (int j = 0; j < NB_CORES; j++)
            begin
                byp_wait[j] <= 3'd0;
                fl_wait[j]  <= 3'd0;
            end
        end
        else
        begin
            for (int j = 0; j < NB_CORES; j++)
            begin
                if (core_ack.bypass_ack[j] != core_req.bypass_req[j])
                begin
                    if (byp_wait[j] == 3'd0)
                        core_ack.bypass_ack[j] <= core_req.bypass_req[j];
                    else
                        byp_wait[j] <= byp_wait[j] - 3'd1;
                end
                else
                    byp_wait[j] <= next_delay();

                if (core_req.flush_req[j] && !core_ack.flush_ack[j])
                begin
                    if (fl_wait[j] == 3'd0)
                        core_ack.flush_ack[j] <= 1'b1; // One cycle pulse
                    else
                        fl_wait[j] <= fl_wait[j] - 3'd1;
                end
                else
                begin
                    core_ack.flush_ack[j] <= 1'b0;
                    fl_wait[j]            <= next_delay();
                end
            end
        end
    end

    always @(posedge clk_i)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit)
            abort_run($sformatf("Timed out after %0d cycles before the stimulus ended",
                                cycle_count));
    end

    task automatic set_request(input logic is_read, input logic [7:0] addr,
                               input logic [31:0] data, input logic [4:0] id);
        bus_req.req   <= 1'b1;
        bus_req.addr  <= {24'h0, addr};
        bus_req.wen   <= is_read;
        bus_req.wdata <= data;
        bus_req.be    <= 4'hF;
        bus_req.id    <= id;
    endtask

    task automatic wait_grant();
        do
            @(negedge clk_i);
        while (bus_rsp.gnt !== 1'b1);
    endtask

    task automatic check_response(input logic [31:0] expected, input logic [4:0] id);
        check_value("r_valid", 32'(bus_rsp.r_valid), 32'h1);
        check_value("r_rdata", bus_rsp.r_rdata, expected);
        check_value("r_id", 32'(bus_rsp.r_id), 32'(id));
        check_value("r_opc", 32'(bus_rsp.r_opc), 32'h0);
    endtask

    task automatic run_read(input logic [7:0] addr, input logic [31:0] expected,
                            input logic [4:0] id);
        @(posedge clk_i);
        set_request(1'b1, addr, 32'h0, id);
        wait_grant();
        @(posedge clk_i);
        bus_req.req <= 1'b0;
        @(negedge clk_i);
        check_response(expected, id); // Read data due one cycle after acceptance
    endtask

    task automatic run_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic [4:0] id);
        logic [5:0]          word;
        logic [NB_CORES-1:0] mask;
        logic [NB_CORES-1:0] inv_mask;
        logic [NB_CORES-1:0] pulsed;
        int                  wait_cycles;
        word        = addr[7:2];
        mask        = data[NB_CORES-1:0];
        inv_mask    = ~mask;
        pulsed      = '0;
        wait_cycles = 0;
        @(posedge clk_i);
        set_request(1'b0, addr, data, id);
        wait_grant();
        @(posedge clk_i);
        set_request(1'b1, PROBE_ADDR, 32'h0, ~id); // Read queued behind the write
        @(negedge clk_i);
        if (word == 6'd1)
            check_value("flush_req", 32'(core_req.flush_req), 32'(mask));
        while (bus_rsp.r_valid !== 1'b1)
        begin
            check_value("gnt", 32'(bus_rsp.gnt), 32'h0);
            pulsed |= core_ack.flush_ack & core_req.flush_req;
            wait_cycles++;
            @(negedge clk_i);
        end
        check_response(32'h0, id);
        check_value("gnt", 32'(bus_rsp.gnt), 32'h1);
        case (word)
            6'd0:
            begin
                check_value("bypass_req", 32'(core_req.bypass_req), 32'(inv_mask));
                check_value("bypass_ack", 32'(core_ack.bypass_ack), 32'(inv_mask));
            end
            6'd1:
            begin
                check_value("flush_ack", 32'(pulsed), 32'(mask));
                check_value("flush_req", 32'(core_req.flush_req), 32'h0);
            end
            default:
            begin
                check_value("write wait cycles", wait_cycles, 32'h0);
            end
        endcase
        @(posedge clk_i);
        bus_req.req <= 1'b0;
        @(negedge clk_i);
        check_response(PROBE_WORD, ~id);
    endtask

    task automatic run_line(input logic [51:0] entry);
        case (entry[51:48])
            OP_READ:  run_read(entry[47:40], entry[39:8], entry[4:0]);
            OP_WRITE: run_write(entry[47:40], entry[39:8], entry[4:0]);
            default:  abort_run("Stimulus file holds an unknown operation code");
        endcase
    endtask

    initial
    begin
        bus_req  <= '0;
        rst_ni   <= 1'b0;
        core_ack <= {{NB_CORES{1'b1}}, {NB_CORES{1'b0}}};
        $readmemh("tests/icache_ctrl_unit_stim.txt", stim_mem);
        num_lines = -1;
        for (int i = MAX_LINES - 1; i >= 0; i--)
        begin
            if (stim_mem[i[5:0]][51:48] === OP_END)
                num_lines = i;
        end
        if (num_lines < 0)
            abort_run("Stimulus file has no end record");
        cycle_limit = 40 * num_lines + 50;

        repeat (2) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        check_value("bypass_req", 32'(core_req.bypass_req), 32'({NB_CORES{1'b1}}));
        check_value("flush_req", 32'(core_req.flush_req), 32'h0);

        for (int i = 0; i < num_lines; i++)
            run_line(stim_mem[i[5:0]]);

        if (error_count == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire
